// File: Bender.yml
package:
  name: qr_accel

sources:
  # Package first, then leaf modules, then the top level
  - files:
      - hw/qr_accel_pkg.sv
      - hw/command_decoder.sv
      - hw/vector_bank.sv
      - hw/result_packer.sv
      - hw/qr_accel_top.sv

  # Testbench
  - target: test
    files:
      - verif/tb_qr_accel.sv

// File: hw/command_decoder.sv
`timescale 1ns/100ps

module command_decoder import qr_accel_pkg::*; (
    input  logic                  clk,
    input  logic                  is_reset_signal_written,
    // Host strobes
    input  logic                  fn_wr,
    input  logic                  start_wr,
    input  logic                  soft_reset_wr,
    input  logic                  line_valid,
    input  line_t                 line_data,
    // Per-lane write command
    output logic [NUM_LANES-1:0]  write_valid,
    output col_t [NUM_LANES-1:0]  write_column,
    output row_t [NUM_LANES-1:0]  write_row,
    output vec_t [NUM_LANES-1:0]  write_vec,
    // Per-lane read command
    output logic [NUM_LANES-1:0]  read_req,
    output col_t [NUM_LANES-1:0]  read_column,
    output row_t [NUM_LANES-1:0]  read_row,
    // Lane output clear
    output logic                  lane_clear,
    // Result select pulse
    output logic                  sel_valid,
    output logic [SEL_BITS-1:0]   sel_lane
);

    ctrl_state_t state;

    // Line taken as a command line
    logic cmd_accept;
    // Line taken as a select line
    logic sel_accept;

    assign cmd_accept = (state == st_run) && line_valid;
    assign sel_accept = (state == st_output) && line_valid;

    // Hard reset or the one-cycle soft reset state
    assign lane_clear = is_reset_signal_written || (state == st_reset);

    // ==================================================================
    // Control FSM
    // ==================================================================

    always_ff @(posedge clk) begin
        if (is_reset_signal_written) begin
            state <= st_waiting_input;
        end else begin
            case (state)
                // Function write opens the command path
                st_waiting_input: begin
                    if (fn_wr) begin
                        state <= st_idle;
                    end
                end
                // Soft reset wins over start
                st_idle: begin
                    if (soft_reset_wr) begin
                        state <= st_reset;
                    end else if (start_wr) begin
                        state <= st_run;
                    end
                end
                // Waiting for the command line
                st_run: begin
                    if (cmd_accept) begin
                        state <= st_output;
                    end
                end
                // Waiting for the select line
                st_output: begin
                    if (sel_accept) begin
                        state <= st_idle;
                    end
                end
                st_reset: begin
                    state <= st_idle;
                end
                default: begin
                    state <= st_waiting_input;
                end
            endcase
        end
    end

    // ==================================================================
    // Command and select strobes
    // ==================================================================

    // Valid bits only for the cycle after the accepting edge
    always_ff @(posedge clk) begin
        if (is_reset_signal_written) begin
            write_valid <= '0;
            read_req    <= '0;
            sel_valid   <= 1'b0;
        end else begin
            sel_valid <= sel_accept;
            for (int n = 0; n < NUM_LANES; n++) begin
                write_valid[n] <= cmd_accept && line_data[n*LANE_CMD_BITS + WR_VALID_OFS];
                read_req[n]    <= cmd_accept && line_data[n*LANE_CMD_BITS + RD_REQ_OFS];
            end
        end
    end

    // Field capture, qualified by the strobes above
    always_ff @(posedge clk) begin
        if (cmd_accept) begin
            for (int n = 0; n < NUM_LANES; n++) begin
                write_column[n] <= line_data[n*LANE_CMD_BITS + WR_COL_OFS +: COL_BITS];
                write_row[n]    <= line_data[n*LANE_CMD_BITS + WR_ROW_OFS +: ROW_BITS];
                write_vec[n]    <= line_data[n*LANE_CMD_BITS + WR_VEC_OFS +: VEC_BITS];
                read_column[n]  <= line_data[n*LANE_CMD_BITS + RD_COL_OFS +: COL_BITS];
                read_row[n]     <= line_data[n*LANE_CMD_BITS + RD_ROW_OFS +: ROW_BITS];
            end
        end
        // Select field in the low bits
        if (sel_accept) begin
            sel_lane <= line_data[0 +: SEL_BITS];
        end
    end

    // ==================================================================
    // Checks
    // ==================================================================

    // Lane commands only right after a command line
    assert property (@(posedge clk) disable iff (is_reset_signal_written)
        ((|write_valid) || (|read_req)) |-> $past(cmd_accept));

    // One select pulse per select line
    assert property (@(posedge clk) disable iff (is_reset_signal_written)
        sel_valid |=> !sel_valid);

endmodule

// File: hw/qr_accel_pkg.sv
package qr_accel_pkg;

    // ==================================================================
    // Host line geometry
    // ==================================================================

    // One host line, 64 bytes
    localparam int LINE_BITS = 512;

    // Lanes served by one command line
    localparam int NUM_LANES = 2;

    // Lane select field, low bits of the select line
    localparam int SEL_BITS = 4;

    // ==================================================================
    // Vector store geometry
    // ==================================================================

    // Floats per vector
    localparam int VEC_LEN = 4;

    // Single-precision split
    localparam int EXP_BITS  = 8;
    localparam int FRAC_BITS = 23;

    // Store index widths, 8 rows by 4 columns
    localparam int COL_BITS = 2;
    localparam int ROW_BITS = 3;

    // ==================================================================
    // Lane command layout, offsets inside one lane slot
    // ==================================================================

    // Slot n starts at bit n * LANE_CMD_BITS
    localparam int LANE_CMD_BITS = 140;

    // Write half of the command
    localparam int WR_VALID_OFS = 0;
    localparam int WR_COL_OFS   = 1;
    localparam int WR_ROW_OFS   = 3;
    localparam int WR_VEC_OFS   = 6;

    // Read half of the command
    localparam int RD_REQ_OFS = 134;
    localparam int RD_COL_OFS = 135;
    localparam int RD_ROW_OFS = 137;

    // Result slot, {rd_valid, rd_data}
    localparam int LANE_RES_BITS = 129;

    // ==================================================================
    // Types
    // ==================================================================

    // IEEE 754 single, sign on top
    typedef struct packed {
        logic                 sign;
        logic [EXP_BITS-1:0]  exp;
        logic [FRAC_BITS-1:0] frac;
    } float_t;

    // Element 0 sits in the low word
    typedef float_t [VEC_LEN-1:0] vec_t;

    localparam int VEC_BITS = $bits(vec_t);

    typedef logic [LINE_BITS-1:0] line_t;
    typedef logic [COL_BITS-1:0]  col_t;
    typedef logic [ROW_BITS-1:0]  row_t;

    // Controller states
    typedef enum logic [2:0] {
        st_waiting_input,
        st_idle,
        st_run,
        st_output,
        st_reset
    } ctrl_state_t;

endpackage

// File: hw/qr_accel_top.sv
`timescale 1ns/100ps

module qr_accel_top import qr_accel_pkg::*; (
    input  logic  clk,
    input  logic  is_reset_signal_written,
    // Host writes
    input  logic  fn_wr,
    input  logic  start_wr,
    input  logic  soft_reset_wr,
    // Host line in
    input  logic  line_valid,
    input  line_t line_data,
    // Result line out
    output logic  result_valid,
    output line_t result_data
);

    // ==================================================================
    // Interconnect
    // ==================================================================

    // Decoder to banks
    wire logic [NUM_LANES-1:0] write_valid;
    wire col_t [NUM_LANES-1:0] write_column;
    wire row_t [NUM_LANES-1:0] write_row;
    wire vec_t [NUM_LANES-1:0] write_vec;
    wire logic [NUM_LANES-1:0] read_req;
    wire col_t [NUM_LANES-1:0] read_column;
    wire row_t [NUM_LANES-1:0] read_row;
    wire logic                 lane_clear;

    // Decoder to packer
    wire logic                 sel_valid;
    wire logic [SEL_BITS-1:0]  sel_lane;

    // Banks to packer
    wire logic [NUM_LANES-1:0] rd_valid;
    wire vec_t [NUM_LANES-1:0] rd_data;

    // ==================================================================
    // Command decode
    // ==================================================================

    command_decoder u_command_decoder (
        .clk                     (clk),
        .is_reset_signal_written (is_reset_signal_written),
        .fn_wr                   (fn_wr),
        .start_wr                (start_wr),
        .soft_reset_wr           (soft_reset_wr),
        .line_valid              (line_valid),
        .line_data               (line_data),
        .write_valid             (write_valid),
        .write_column            (write_column),
        .write_row               (write_row),
        .write_vec               (write_vec),
        .read_req                (read_req),
        .read_column             (read_column),
        .read_row                (read_row),
        .lane_clear              (lane_clear),
        .sel_valid               (sel_valid),
        .sel_lane                (sel_lane)
    );

    // ==================================================================
    // Lane stores
    // ==================================================================

    // One bank per lane, shared clear
    for (genvar n = 0; n < NUM_LANES; n++) begin : g_lane
        vector_bank u_vector_bank (
            .clk          (clk),
            .lane_clear   (lane_clear),
            .write_valid  (write_valid[n]),
            .write_column (write_column[n]),
            .write_row    (write_row[n]),
            .write_vec    (write_vec[n]),
            .read_req     (read_req[n]),
            .read_column  (read_column[n]),
            .read_row     (read_row[n]),
            .rd_valid     (rd_valid[n]),
            .rd_data      (rd_data[n])
        );
    end

    // Result line build
    result_packer u_result_packer (
        .clk                     (clk),
        .is_reset_signal_written (is_reset_signal_written),
        .sel_valid               (sel_valid),
        .sel_lane                (sel_lane),
        .rd_valid                (rd_valid),
        .rd_data                 (rd_data),
        .result_valid            (result_valid),
        .result_data             (result_data)
    );

endmodule

// File: hw/result_packer.sv
`timescale 1ns/100ps

module result_packer import qr_accel_pkg::*; (
    input  logic                  clk,
    input  logic                  is_reset_signal_written,
    // Select pulse from the decoder
    input  logic                  sel_valid,
    input  logic [SEL_BITS-1:0]   sel_lane,
    // Lane read outputs
    input  logic [NUM_LANES-1:0]  rd_valid,
    input  vec_t [NUM_LANES-1:0]  rd_data,
    // Result line toward the host
    output logic                  result_valid,
    output line_t                 result_data
);

    // Line with only the selected slot filled
    line_t slot_line;

    // ==================================================================
    // Slot placement
    // ==================================================================

    // Slots side by side, rd_valid above the data
    // Out-of-range selects leave the line zero
    always_comb begin
        slot_line = '0;
        for (int n = 0; n < NUM_LANES; n++) begin
            if (sel_lane == SEL_BITS'(n)) begin
                slot_line[n*LANE_RES_BITS +: LANE_RES_BITS] = {rd_valid[n], rd_data[n]};
            end
        end
    end

    // ==================================================================
    // Output registers
    // ==================================================================

    always_ff @(posedge clk) begin
        if (is_reset_signal_written) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= sel_valid;
        end
    end

    // Data only moves with a select
    always_ff @(posedge clk) begin
        if (sel_valid) begin
            result_data <= slot_line;
        end
    end

    // One result per select, one cycle later
    assert property (@(posedge clk) disable iff (is_reset_signal_written)
        result_valid == $past(sel_valid));

endmodule

// File: hw/vector_bank.sv
`timescale 1ns/100ps

module vector_bank import qr_accel_pkg::*; (
    input  logic clk,
    // Clears the read output, store untouched
    input  logic lane_clear,
    // Write command
    input  logic write_valid,
    input  col_t write_column,
    input  row_t write_row,
    input  vec_t write_vec,
    // Read command
    input  logic read_req,
    input  col_t read_column,
    input  row_t read_row,
    // Last read
    output logic rd_valid,
    output vec_t rd_data
);

    // Row-major, row in the high address bits
    localparam int ADDR_BITS = ROW_BITS + COL_BITS;
    localparam int DEPTH     = 2 ** ADDR_BITS;

    vec_t store [DEPTH];

    logic [ADDR_BITS-1:0] wr_addr;
    logic [ADDR_BITS-1:0] rd_addr;

    assign wr_addr = {write_row, write_column};
    assign rd_addr = {read_row, read_column};

    // ==================================================================
    // Vector store
    // ==================================================================

    // Plain storage, survives soft reset
    always_ff @(posedge clk) begin
        if (write_valid) begin
            store[wr_addr] <= write_vec;
        end
    end

    // ==================================================================
    // Read port
    // ==================================================================

    // Sees the store before this edge's write
    // Same-entry read and write returns old contents
    always_ff @(posedge clk) begin
        if (lane_clear) begin
            rd_valid <= 1'b0;
            rd_data  <= '0;
        end else if (read_req) begin
            rd_valid <= 1'b1;
            rd_data  <= store[rd_addr];
        end
    end

    // Output empty right after a clear
    assert property (@(posedge clk)
        lane_clear |=> !rd_valid);

endmodule

// File: sources.f
hw/qr_accel_pkg.sv
hw/command_decoder.sv
hw/vector_bank.sv
hw/result_packer.sv
hw/qr_accel_top.sv
verif/tb_qr_accel.sv

// File: verif/tb_qr_accel.sv
`timescale 1ns/100ps

module tb_qr_accel import qr_accel_pkg::*; ();

    // One host-side lane command before packing
    typedef struct packed {
        logic wv;
        col_t wcol;
        row_t wrow;
        vec_t wvec;
        logic rr;
        col_t rcol;
        row_t rrow;
    } lane_cmd_t;

    typedef enum logic [2:0] {
        step_fn,
        step_start,
        step_soft_reset,
        step_cmd,
        step_sel,
        step_stray
    } step_kind_t;

    // Table row, expected line only used on select rows
    typedef struct packed {
        step_kind_t kind;
        line_t      line;
        line_t      exp_line;
    } step_t;

    logic  clk;
    logic  is_reset_signal_written;
    logic  fn_wr;
    logic  start_wr;
    logic  soft_reset_wr;
    logic  line_valid;
    line_t line_data;
    logic  result_valid;
    line_t result_data;

    step_t       steps [$];
    int          cycle_limit;
    logic [31:0] lfsr_state;

    // Reference model of the lanes and the controller
    vec_t                 model_store [NUM_LANES][2 ** (ROW_BITS + COL_BITS)];
    logic [NUM_LANES-1:0] last_valid;
    vec_t [NUM_LANES-1:0] last_data;
    ctrl_state_t          model_state;

    qr_accel_top u_qr_accel_top (
        .clk                     (clk),
        .is_reset_signal_written (is_reset_signal_written),
        .fn_wr                   (fn_wr),
        .start_wr                (start_wr),
        .soft_reset_wr           (soft_reset_wr),
        .line_valid              (line_valid),
        .line_data               (line_data),
        .result_valid            (result_valid),
        .result_data             (result_data)
    );

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ==================================================================
    // Stimulus helpers
    // ==================================================================

    // Right-shift Galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per vector bit
    task automatic make_vec(output vec_t v);
        logic [VEC_BITS-1:0] bits;
        for (int b = 0; b < VEC_BITS; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits[b] = lfsr_state[0];
        end
        v = vec_t'(bits);
    endtask

    function automatic lane_cmd_t write_cmd(input row_t r, input col_t c, input vec_t v);
        lane_cmd_t cmd;
        cmd = '0;
        cmd.wv = 1'b1;
        cmd.wrow = r;
        cmd.wcol = c;
        cmd.wvec = v;
        return cmd;
    endfunction

    function automatic lane_cmd_t read_cmd(input row_t r, input col_t c);
        lane_cmd_t cmd;
        cmd = '0;
        cmd.rr = 1'b1;
        cmd.rrow = r;
        cmd.rcol = c;
        return cmd;
    endfunction

    // Read and write of the same entry
    function automatic lane_cmd_t rw_cmd(input row_t r, input col_t c, input vec_t v);
        lane_cmd_t cmd;
        cmd = write_cmd(r, c, v);
        cmd.rr = 1'b1;
        cmd.rrow = r;
        cmd.rcol = c;
        return cmd;
    endfunction

    // Lane slot n at n * LANE_CMD_BITS
    function automatic line_t place_cmd(input line_t line, input int lane, input lane_cmd_t c);
        line_t l;
        int    base;
        l = line;
        base = lane * LANE_CMD_BITS;
        l[base + WR_VALID_OFS] = c.wv;
        l[base + WR_COL_OFS +: COL_BITS] = c.wcol;
        l[base + WR_ROW_OFS +: ROW_BITS] = c.wrow;
        l[base + WR_VEC_OFS +: VEC_BITS] = c.wvec;
        l[base + RD_REQ_OFS] = c.rr;
        l[base + RD_COL_OFS +: COL_BITS] = c.rcol;
        l[base + RD_ROW_OFS +: ROW_BITS] = c.rrow;
        return l;
    endfunction

    // ==================================================================
    // Table building, model runs alongside
    // ==================================================================

    task automatic push_step(input step_kind_t kind, input line_t line, input line_t exp_line);
        step_t s;
        s.kind = kind;
        s.line = line;
        s.exp_line = exp_line;
        steps.push_back(s);
    endtask

    task automatic add_fn();
        if (model_state == st_waiting_input) begin
            model_state = st_idle;
        end
        push_step(step_fn, '0, '0);
    endtask

    task automatic add_start();
        if (model_state == st_idle) begin
            model_state = st_run;
        end
        push_step(step_start, '0, '0);
    endtask

    // Clears last reads, store kept; st_reset is one cycle
    task automatic add_soft_reset();
        if (model_state == st_idle) begin
            last_valid = '0;
            last_data = '0;
        end
        push_step(step_soft_reset, '0, '0);
    endtask

    // Read sees the store before the write
    task automatic exec_lane(input int n, input lane_cmd_t c);
        if (c.rr) begin
            last_valid[n] = 1'b1;
            last_data[n] = model_store[n][{c.rrow, c.rcol}];
        end
        if (c.wv) begin
            model_store[n][{c.wrow, c.wcol}] = c.wvec;
        end
    endtask

    task automatic add_cmd(input lane_cmd_t c0, input lane_cmd_t c1);
        if (model_state == st_run) begin
            exec_lane(0, c0);
            exec_lane(1, c1);
            model_state = st_output;
        end
        push_step(step_cmd, place_cmd(place_cmd('0, 0, c0), 1, c1), '0);
    endtask

    // Selected slot holds {rd_valid, rd_data}, rest zero
    task automatic add_sel(input logic [SEL_BITS-1:0] sel);
        line_t line;
        line_t exp_line;
        int    base;
        line = '0;
        line[0 +: SEL_BITS] = sel;
        exp_line = '0;
        if (sel < NUM_LANES) begin
            base = sel * LANE_RES_BITS;
            exp_line[base +: VEC_BITS] = last_data[sel];
            exp_line[base + VEC_BITS] = last_valid[sel];
        end
        model_state = st_idle;
        push_step(step_sel, line, exp_line);
    endtask

    task automatic add_stray(input line_t line);
        push_step(step_stray, line, '0);
    endtask

    task automatic run_cmd_sel(input lane_cmd_t c0, input lane_cmd_t c1,
                               input logic [SEL_BITS-1:0] sel);
        add_start();
        add_cmd(c0, c1);
        add_sel(sel);
    endtask

    task automatic build_table();
        vec_t va [4];
        vec_t vb [4];
        vec_t vc;
        vec_t vd;
        for (int k = 0; k < 4; k++) begin
            make_vec(va[k]);
            make_vec(vb[k]);
        end
        make_vec(vc);
        make_vec(vd);
        // Ignored until the function write
        add_start();
        add_stray('0);
        add_stray(place_cmd('0, 0, write_cmd(3'd4, 2'd1, vc)));
        add_fn();
        // Fill both lanes
        run_cmd_sel(write_cmd(3'd0, 2'd0, va[0]), write_cmd(3'd5, 2'd3, vb[0]), 4'd0);
        run_cmd_sel(write_cmd(3'd3, 2'd1, va[1]), write_cmd(3'd2, 2'd2, vb[1]), 4'd1);
        run_cmd_sel(write_cmd(3'd7, 2'd3, va[2]), write_cmd(3'd0, 2'd0, vb[2]), 4'd0);
        // Read back, idle commands show the held read
        run_cmd_sel(read_cmd(3'd0, 2'd0), read_cmd(3'd5, 2'd3), 4'd0);
        run_cmd_sel('0, '0, 4'd1);
        run_cmd_sel(read_cmd(3'd3, 2'd1), read_cmd(3'd2, 2'd2), 4'd1);
        run_cmd_sel('0, '0, 4'd0);
        run_cmd_sel(read_cmd(3'd7, 2'd3), read_cmd(3'd0, 2'd0), 4'd0);
        // Same-entry read and write
        run_cmd_sel(rw_cmd(3'd3, 2'd1, va[3]), rw_cmd(3'd0, 2'd0, vb[3]), 4'd0);
        run_cmd_sel('0, '0, 4'd1);
        run_cmd_sel(read_cmd(3'd3, 2'd1), '0, 4'd0);
        // Soft reset drops the reads, store survives
        add_soft_reset();
        run_cmd_sel('0, '0, 4'd0);
        run_cmd_sel('0, '0, 4'd1);
        run_cmd_sel('0, read_cmd(3'd0, 2'd0), 4'd1);
        // Out-of-range selects, both lanes hold a valid read
        run_cmd_sel(read_cmd(3'd0, 2'd0), '0, 4'd2);
        run_cmd_sel('0, '0, 4'd15);
        // Stray line in st_idle must not write
        add_stray(place_cmd(place_cmd('0, 0, write_cmd(3'd3, 2'd1, vc)), 1,
                            write_cmd(3'd0, 2'd0, vd)));
        run_cmd_sel(read_cmd(3'd3, 2'd1), read_cmd(3'd0, 2'd0), 4'd0);
        run_cmd_sel('0, '0, 4'd1);
    endtask

    // ==================================================================
    // Checks
    // ==================================================================

    task automatic check_line(input string name, input line_t got, input line_t exp_val);
        if (got !== exp_val) begin
            $display("FAIL %s got %h expected %h", name, got, exp_val);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp_val);
        if (got !== exp_val) begin
            $display("FAIL %s got %h expected %h", name, got, exp_val);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    endtask

    // One strobe cycle, then three cycles watched at the falling edge
    task automatic apply_step(input int idx);
        step_t s;
        s = steps[idx];
        @(posedge clk);
        case (s.kind)
            step_fn:         fn_wr <= 1'b1;
            step_start:      start_wr <= 1'b1;
            step_soft_reset: soft_reset_wr <= 1'b1;
            default: begin
                line_valid <= 1'b1;
                line_data <= s.line;
            end
        endcase
        @(posedge clk);
        fn_wr <= 1'b0;
        start_wr <= 1'b0;
        soft_reset_wr <= 1'b0;
        line_valid <= 1'b0;
        line_data <= '0;
        for (int k = 0; k < 3; k++) begin
            @(negedge clk);
            // Result in the second cycle after the select line edge
            if (s.kind == step_sel && k == 1) begin
                check_flag("result_valid", result_valid, 1'b1);
                check_line("result_data", result_data, s.exp_line);
            end else begin
                check_flag("result_valid", result_valid, 1'b0);
            end
        end
    endtask

    // ==================================================================
    // Run
    // ==================================================================

    initial begin
        is_reset_signal_written = 1'b1;
        fn_wr = 1'b0;
        start_wr = 1'b0;
        soft_reset_wr = 1'b0;
        line_valid = 1'b0;
        line_data = '0;
        lfsr_state = 32'h2900_b40b;
        model_state = st_waiting_input;
        last_valid = '0;
        last_data = '0;
        build_table();
        cycle_limit = steps.size() * 4 + 20;
        repeat (2) @(posedge clk);
        is_reset_signal_written <= 1'b0;
        for (int i = 0; i < steps.size(); i++) begin
            apply_step(i);
        end
        $display("SIMULATION PASSED");
        $finish;
    end

    // Limit set at time zero, counted in clock cycles
    initial begin
        int cycles;
        cycles = 0;
        #1;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the table did not complete", cycle_limit);
        $display("SIMULATION FAILED");
        $fatal(1);
    end

endmodule
